// ==== verilog.f ====
+incdir+tb
common/la32_decode_pkg.sv
hdl/fetch_port.sv
decode/imm_gen.sv
decode/inst_decoder.sv
hdl/decode_port.sv
hdl/la32_decode_top.sv
tb/la32_decode_assert.sv
tb/tb_la32_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -sv -f verilog.f --top-module tb_la32_decode -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "test failed" sim.log; then
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    exit 1
fi
exit 0

// ==== tb/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH
`default_nettype none

// Columns: ir, pc, class, alu_op, src1, src2, sub_op, redirect, reg_write, mem_read,
// mem_write, rk, rj, rd, imm, excp_valid, excp_code, excp_subcode
task automatic load_vectors;
    add_vec('h00101483, 'h1c000000, 0, 4, 0, 0, 0, 0, 1, 0, 0, 5, 4, 3, 'h0, 0, 0, 0);  // ADD.W
    add_vec('h00111483, 'h1c000004, 0, 5, 0, 0, 0, 0, 1, 0, 0, 5, 4, 3, 'h0, 0, 0, 0);  // SUB.W
    add_vec('h00159483, 'h1c000008, 0, 3, 0, 0, 0, 0, 1, 0, 0, 5, 4, 3, 'h0, 0, 0, 0);  // XOR
    add_vec('h00181483, 'h1c00000c, 0, 8, 0, 0, 0, 0, 1, 0, 0, 5, 4, 3, 'h0, 0, 0, 0);  // SRA.W
    add_vec('h00409483, 'h1c000010, 0, 6, 0, 1, 0, 0, 1, 0, 0, 0, 4, 3, 'h5, 0, 0, 0);  // SLLI.W
    add_vec('h0048fc83, 'h1c000014, 0, 8, 0, 1, 0, 0, 1, 0, 0, 0, 4, 3, 'h1f, 0, 0, 0); // SRAI.W
    add_vec('h02bff083, 'h1c000018, 0, 4, 0, 1, 0, 0, 1, 0, 0, 0, 4, 3, 'hfffffffc, 0, 0, 0);
    add_vec('h03600083, 'h1c00001c, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 4, 3, 'h800, 0, 0, 0); // ANDI
    add_vec('h15000023, 'h1c000020, 0, 11, 0, 1, 0, 0, 1, 0, 0, 0, 0, 3, 'h80001000, 0, 0, 0);
    add_vec('h1c000203, 'h1c000024, 0, 4, 1, 1, 0, 0, 1, 0, 0, 0, 0, 3, 'h10000, 0, 0, 0);
    add_vec('h28802083, 'h1c000028, 2, 4, 0, 1, 2, 0, 1, 1, 0, 0, 4, 3, 'h8, 0, 0, 0);  // LD.W
    add_vec('h2a3ffc83, 'h1c00002c, 2, 4, 0, 1, 6, 0, 1, 1, 0, 0, 4, 3, 'hffffffff, 0, 0, 0);
    add_vec('h29002083, 'h1c000030, 2, 4, 0, 1, 3, 0, 0, 0, 1, 0, 4, 3, 'h8, 0, 0, 0);  // ST.B
    add_vec('h29802083, 'h1c000034, 2, 4, 0, 1, 5, 0, 0, 0, 1, 0, 4, 3, 'h8, 0, 0, 0);  // ST.W
    add_vec('h4c001081, 'h1c000038, 4, 4, 1, 3, 0, 1, 1, 0, 0, 0, 4, 1, 'h10, 0, 0, 0); // JIRL
    add_vec('h53fffbff, 'h1c00003c, 1, 4, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 'hfffffff8, 0, 0, 0);
    add_vec('h54004000, 'h1c000040, 4, 4, 1, 3, 0, 1, 1, 0, 0, 0, 0, 1, 'h40, 0, 0, 0); // BL
    add_vec('h5bfff083, 'h1c000044, 1, 5, 0, 2, 1, 1, 0, 0, 0, 0, 4, 3, 'hfffffff0, 0, 0, 0);
    add_vec('h5c001083, 'h1c000048, 1, 5, 0, 2, 2, 1, 0, 0, 0, 0, 4, 3, 'h10, 0, 0, 0); // BNE
    add_vec('h60001083, 'h1c00004c, 1, 9, 0, 2, 3, 1, 0, 0, 0, 0, 4, 3, 'h10, 0, 0, 0); // BLT
    add_vec('h64001083, 'h1c000050, 1, 9, 0, 2, 4, 1, 0, 0, 0, 0, 4, 3, 'h10, 0, 0, 0); // BGE
    add_vec('h68001083, 'h1c000054, 1, 10, 0, 2, 5, 1, 0, 0, 0, 0, 4, 3, 'h10, 0, 0, 0);
    add_vec('h6c001083, 'h1c000058, 1, 10, 0, 2, 6, 1, 0, 0, 0, 0, 4, 3, 'h10, 0, 0, 0);
    add_vec('h00101483, 'h1c00005a, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h0, 1, 'h08, 0); // ADEF
    add_vec('h00101483, 'h80000000, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h0, 1, 'h08, 1); // ADEM
    add_vec('h002a0000, 'h1c00005c, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h0, 1, 'h0c, 0); // BREAK
    add_vec('h002b0000, 'h1c000060, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h0, 1, 'h0b, 0);
    add_vec('h001c1483, 'h1c000064, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h0, 1, 'h0d, 0); // MUL.W
    add_vec('hffffffff, 'h1c000068, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h0, 1, 'h0d, 0);
endtask

`default_nettype wire
`endif

// ==== tb/tb_la32_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_la32_decode
    import la32_decode_pkg::*;
;

    localparam int MAX_VEC = 40;
    localparam int NUM_COL = 18;
    localparam int TIMEOUT = 200;  // Cycles per wait

    logic                 clk;
    logic                 rst_n;
    logic                 in_req;
    logic                 in_ack;
    logic [XLEN-1:0]      ir;
    logic [XLEN-1:0]      pc;
    logic                 out_req;
    logic                 out_ack;
    logic [CLASS_W-1:0]   out_inst_class;
    logic [ALU_OP_W-1:0]  out_alu_op;
    logic                 out_src1_sel;
    logic [1:0]           out_src2_sel;
    logic [SUB_OP_W-1:0]  out_sub_op;
    logic                 out_pc_redirect;
    logic                 out_reg_write;
    logic                 out_mem_read;
    logic                 out_mem_write;
    logic [REG_IDX_W-1:0] out_rk;
    logic [REG_IDX_W-1:0] out_rj;
    logic [REG_IDX_W-1:0] out_rd;
    logic [XLEN-1:0]      out_imm;
    logic [XLEN-1:0]      out_pc_out;
    logic                 out_excp_valid;
    logic [ECODE_W-1:0]   out_excp_code;
    logic                 out_excp_subcode;

    logic [31:0] vec [0:MAX_VEC-1][0:NUM_COL-1];
    int          num_vec;

    la32_decode_top i_dut (.*);

    bind la32_decode_top la32_decode_assert i_assert (.*);

    always #20 clk = ~clk;

    task automatic add_vec(input logic [31:0] v_ir, v_pc, v_cls, v_alu, v_s1, v_s2, v_sub,
                           v_redir, v_wr, v_mrd, v_mwr, v_rk, v_rj, v_rd, v_imm,
                           v_excp, v_code, v_subcode);
        vec[num_vec] = '{v_ir, v_pc, v_cls, v_alu, v_s1, v_s2, v_sub, v_redir, v_wr, v_mrd,
                         v_mwr, v_rk, v_rj, v_rd, v_imm, v_excp, v_code, v_subcode};
        num_vec++;
    endtask

    `include "tb_vectors.svh"

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        $display("test failed");
        $fatal(1);
    endtask

    // Waits at falling edges until in_ack reaches level
    task automatic wait_ack(input logic level, input string what);
        int cnt;
        cnt = 0;
        while (in_ack !== level)
        begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT)
                timeout_fail(what);
        end
    endtask

    // Waits at falling edges until out_req reaches level
    task automatic wait_req(input logic level, input string what);
        int cnt;
        cnt = 0;
        while (out_req !== level)
        begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT)
                timeout_fail(what);
        end
    endtask

    task automatic drive_requests;
        for (int i = 0; i < num_vec; i++)
        begin
            @(negedge clk);
            ir     = vec[i][0];
            pc     = vec[i][1];
            in_req = 1'b1;
            wait_ack(1'b1, "in_ack high");
            in_req = 1'b0;
            wait_ack(1'b0, "in_ack low");
        end
    endtask

    task automatic collect_results;
        int delay;
        for (int i = 0; i < num_vec; i++)
        begin
            wait_req(1'b1, "out_req high");
            check("out_inst_class", 32'(out_inst_class), vec[i][2]);
            check("out_alu_op", 32'(out_alu_op), vec[i][3]);
            check("out_src1_sel", 32'(out_src1_sel), vec[i][4]);
            check("out_src2_sel", 32'(out_src2_sel), vec[i][5]);
            check("out_sub_op", 32'(out_sub_op), vec[i][6]);
            check("out_pc_redirect", 32'(out_pc_redirect), vec[i][7]);
            check("out_reg_write", 32'(out_reg_write), vec[i][8]);
            check("out_mem_read", 32'(out_mem_read), vec[i][9]);
            check("out_mem_write", 32'(out_mem_write), vec[i][10]);
            check("out_rk", 32'(out_rk), vec[i][11]);
            check("out_rj", 32'(out_rj), vec[i][12]);
            check("out_rd", 32'(out_rd), vec[i][13]);
            check("out_imm", out_imm, vec[i][14]);
            check("out_pc_out", out_pc_out, vec[i][1]);
            check("out_excp_valid", 32'(out_excp_valid), vec[i][15]);
            check("out_excp_code", 32'(out_excp_code), vec[i][16]);
            check("out_excp_subcode", 32'(out_excp_subcode), vec[i][17]);
            delay = int'($urandom % 6);  // Random consumer back-pressure
            repeat (delay) @(negedge clk);
            out_ack = 1'b1;
            wait_req(1'b0, "out_req low");
            out_ack = 1'b0;
        end
    endtask

    initial
    begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_req   = 1'b0;
        out_ack  = 1'b0;
        ir       = '0;
        pc       = '0;
        num_vec  = 0;
        void'($urandom(32'h23f9_0aaf));
        load_vectors();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        fork
            drive_requests();
            collect_results();
        join
        repeat (6) @(negedge clk);
        check("out_req", 32'(out_req), 32'd0);  // No extra result after the table
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/la32_decode_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module la32_decode_assert
    import la32_decode_pkg::*;
(
    input wire logic                 clk,
    input wire logic                 rst_n,
    input wire logic                 in_req,
    input wire logic                 in_ack,
    input wire logic                 out_req,
    input wire logic                 out_ack,
    input wire logic [CLASS_W-1:0]   out_inst_class,
    input wire logic [ALU_OP_W-1:0]  out_alu_op,
    input wire logic                 out_src1_sel,
    input wire logic [1:0]           out_src2_sel,
    input wire logic [SUB_OP_W-1:0]  out_sub_op,
    input wire logic                 out_pc_redirect,
    input wire logic                 out_reg_write,
    input wire logic                 out_mem_read,
    input wire logic                 out_mem_write,
    input wire logic [REG_IDX_W-1:0] out_rk,
    input wire logic [REG_IDX_W-1:0] out_rj,
    input wire logic [REG_IDX_W-1:0] out_rd,
    input wire logic [XLEN-1:0]      out_imm,
    input wire logic [XLEN-1:0]      out_pc_out,
    input wire logic                 out_excp_valid,
    input wire logic [ECODE_W-1:0]   out_excp_code,
    input wire logic                 out_excp_subcode
);

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req)
        else $error("out_req dropped before out_ack");

    out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && $past(out_req) |-> $stable({out_inst_class, out_alu_op, out_src1_sel,
                                              out_src2_sel, out_sub_op, out_pc_redirect,
                                              out_reg_write, out_mem_read, out_mem_write,
                                              out_rk, out_rj, out_rd, out_imm, out_pc_out,
                                              out_excp_valid, out_excp_code,
                                              out_excp_subcode}))
        else $error("Decoded outputs changed while out_req high");

    idle_in_reset: assert property (@(posedge clk)
        !rst_n |=> !in_ack && !out_req)
        else $error("Handshake outputs high during reset");

endmodule

`default_nettype wire

// ==== hdl/la32_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module la32_decode_top
    import la32_decode_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_req,
    output logic                 in_ack,
    input  logic [XLEN-1:0]      ir,
    input  logic [XLEN-1:0]      pc,
    output logic                 out_req,
    input  logic                 out_ack,
    output logic [CLASS_W-1:0]   out_inst_class,
    output logic [ALU_OP_W-1:0]  out_alu_op,
    output logic                 out_src1_sel,
    output logic [1:0]           out_src2_sel,
    output logic [SUB_OP_W-1:0]  out_sub_op,
    output logic                 out_pc_redirect,
    output logic                 out_reg_write,
    output logic                 out_mem_read,
    output logic                 out_mem_write,
    output logic [REG_IDX_W-1:0] out_rk,
    output logic [REG_IDX_W-1:0] out_rj,
    output logic [REG_IDX_W-1:0] out_rd,
    output logic [XLEN-1:0]      out_imm,
    output logic [XLEN-1:0]      out_pc_out,
    output logic                 out_excp_valid,
    output logic [ECODE_W-1:0]   out_excp_code,
    output logic                 out_excp_subcode
);

    // Fetch to decode
    logic                 fetch_valid;
    logic                 fetch_take;
    logic [XLEN-1:0]      fetch_ir;
    logic [XLEN-1:0]      fetch_pc;
    logic                 adef;
    logic                 adem;

    // Decode stage register to output port
    logic                 dec_valid;
    logic                 dec_take;
    logic [CLASS_W-1:0]   inst_class;
    logic [ALU_OP_W-1:0]  alu_op;
    logic                 src1_sel;
    logic [1:0]           src2_sel;
    logic [SUB_OP_W-1:0]  sub_op;
    logic                 pc_redirect;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic [REG_IDX_W-1:0] rk;
    logic [REG_IDX_W-1:0] rj;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      pc_out;
    logic                 excp_valid;
    logic [ECODE_W-1:0]   excp_code;
    logic                 excp_subcode;

    fetch_port i_fetch_port (.*);

    inst_decoder i_inst_decoder (.*);

    decode_port i_decode_port (.*);

endmodule

`default_nettype wire

// ==== hdl/decode_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_port
    import la32_decode_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dec_valid,
    output logic                 dec_take,
    input  logic [CLASS_W-1:0]   inst_class,
    input  logic [ALU_OP_W-1:0]  alu_op,
    input  logic                 src1_sel,
    input  logic [1:0]           src2_sel,
    input  logic [SUB_OP_W-1:0]  sub_op,
    input  logic                 pc_redirect,
    input  logic                 reg_write,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic [REG_IDX_W-1:0] rk,
    input  logic [REG_IDX_W-1:0] rj,
    input  logic [REG_IDX_W-1:0] rd,
    input  logic [XLEN-1:0]      imm,
    input  logic [XLEN-1:0]      pc_out,
    input  logic                 excp_valid,
    input  logic [ECODE_W-1:0]   excp_code,
    input  logic                 excp_subcode,
    output logic [CLASS_W-1:0]   out_inst_class,
    output logic [ALU_OP_W-1:0]  out_alu_op,
    output logic                 out_src1_sel,
    output logic [1:0]           out_src2_sel,
    output logic [SUB_OP_W-1:0]  out_sub_op,
    output logic                 out_pc_redirect,
    output logic                 out_reg_write,
    output logic                 out_mem_read,
    output logic                 out_mem_write,
    output logic [REG_IDX_W-1:0] out_rk,
    output logic [REG_IDX_W-1:0] out_rj,
    output logic [REG_IDX_W-1:0] out_rd,
    output logic [XLEN-1:0]      out_imm,
    output logic [XLEN-1:0]      out_pc_out,
    output logic                 out_excp_valid,
    output logic [ECODE_W-1:0]   out_excp_code,
    output logic                 out_excp_subcode,
    output logic                 out_req,
    input  logic                 out_ack
);

    logic full;

    assign dec_take = dec_valid && !full;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            full    <= 1'b0;
            out_req <= 1'b0;
        end
        else if (dec_take)
        begin
            full    <= 1'b1;
            out_req <= 1'b1;
        end
        else if (out_req && out_ack)
            out_req <= 1'b0;
        else if (full && !out_req && !out_ack)
            full <= 1'b0;  // Consumer back at zero, slot free
    end

    always_ff @(posedge clk)
    begin
        if (dec_take)
        begin
            out_inst_class   <= inst_class;
            out_alu_op       <= alu_op;
            out_src1_sel     <= src1_sel;
            out_src2_sel     <= src2_sel;
            out_sub_op       <= sub_op;
            out_pc_redirect  <= pc_redirect;
            out_reg_write    <= reg_write;
            out_mem_read     <= mem_read;
            out_mem_write    <= mem_write;
            out_rk           <= rk;
            out_rj           <= rj;
            out_rd           <= rd;
            out_imm          <= imm;
            out_pc_out       <= pc_out;
            out_excp_valid   <= excp_valid;
            out_excp_code    <= excp_code;
            out_excp_subcode <= excp_subcode;
        end
    end

endmodule

`default_nettype wire

// ==== decode/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import la32_decode_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_valid,
    output logic                 fetch_take,
    input  logic [XLEN-1:0]      fetch_ir,
    input  logic [XLEN-1:0]      fetch_pc,
    input  logic                 adef,
    input  logic                 adem,
    output logic                 dec_valid,
    input  logic                 dec_take,
    output logic [CLASS_W-1:0]   inst_class,
    output logic [ALU_OP_W-1:0]  alu_op,
    output logic                 src1_sel,
    output logic [1:0]           src2_sel,
    output logic [SUB_OP_W-1:0]  sub_op,
    output logic                 pc_redirect,
    output logic                 reg_write,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic [REG_IDX_W-1:0] rk,
    output logic [REG_IDX_W-1:0] rj,
    output logic [REG_IDX_W-1:0] rd,
    output logic [XLEN-1:0]      imm,
    output logic [XLEN-1:0]      pc_out,
    output logic                 excp_valid,
    output logic [ECODE_W-1:0]   excp_code,
    output logic                 excp_subcode
);

    inst_word_u            word;
    logic [16:0]           op17;
    logic [9:0]            op10;  // ir[31:22]
    logic [6:0]            op7;   // ir[31:25]
    logic [5:0]            op6;   // ir[31:26]
    logic                  is_r3, is_shi, is_i12, is_mem, is_br;
    logic [ALU_OP_W-1:0]   tbl_alu;  // From the opcode tables
    logic [SUB_OP_W-1:0]   tbl_sub;
    logic [CLASS_W-1:0]    n_class;
    logic [ALU_OP_W-1:0]   n_alu;
    logic                  n_src1;
    logic [1:0]            n_src2;
    logic [SUB_OP_W-1:0]   n_sub;
    logic                  n_redir, n_wr, n_mrd, n_mwr, n_excp, n_subcode;
    logic [REG_IDX_W-1:0]  n_rk, n_rj, n_rd;
    logic [IMM_FMT_W-1:0]  n_fmt;
    logic [ECODE_W-1:0]    n_code;
    logic [XLEN-1:0]       n_imm;

    assign word = fetch_ir;
    assign op17 = word.reg_view.op17;
    assign op10 = op17[16:7];
    assign op7  = op17[16:10];
    assign op6  = word.imm_view.op6;

    assign fetch_take = fetch_valid && (!dec_valid || dec_take);

    // Opcode tables
    always_comb
    begin
        tbl_alu = ALU_ADD;
        tbl_sub = '0;
        is_r3   = 1'b1;
        is_shi  = 1'b1;
        is_i12  = 1'b1;
        is_mem  = 1'b1;
        is_br   = 1'b1;
        case (op17)
            17'h00020: tbl_alu = ALU_ADD;   // ADD.W
            17'h00022: tbl_alu = ALU_SUB;   // SUB.W
            17'h00024: tbl_alu = ALU_SLT;
            17'h00025: tbl_alu = ALU_SLTU;
            17'h00028: tbl_alu = ALU_NOR;
            17'h00029: tbl_alu = ALU_AND;
            17'h0002a: tbl_alu = ALU_OR;
            17'h0002b: tbl_alu = ALU_XOR;
            17'h0002e: tbl_alu = ALU_SLL;   // SLL.W
            17'h0002f: tbl_alu = ALU_SRL;
            17'h00030: tbl_alu = ALU_SRA;
            default:   is_r3 = 1'b0;
        endcase
        case (op17)
            17'h00081: tbl_alu = ALU_SLL;   // SLLI.W
            17'h00089: tbl_alu = ALU_SRL;   // SRLI.W
            17'h00091: tbl_alu = ALU_SRA;   // SRAI.W
            default:   is_shi = 1'b0;
        endcase
        case (op10)
            10'h008: tbl_alu = ALU_SLT;     // SLTI
            10'h009: tbl_alu = ALU_SLTU;    // SLTUI
            10'h00a: tbl_alu = ALU_ADD;     // ADDI.W
            10'h00d: tbl_alu = ALU_AND;     // ANDI
            10'h00e: tbl_alu = ALU_OR;
            10'h00f: tbl_alu = ALU_XOR;
            default: is_i12 = 1'b0;
        endcase
        case (op10)
            10'h0a0: tbl_sub = MEM_LD_B;
            10'h0a1: tbl_sub = MEM_LD_H;
            10'h0a2: tbl_sub = MEM_LD_W;
            10'h0a4: tbl_sub = MEM_ST_B;
            10'h0a5: tbl_sub = MEM_ST_H;
            10'h0a6: tbl_sub = MEM_ST_W;
            10'h0a8: tbl_sub = MEM_LD_BU;
            10'h0a9: tbl_sub = MEM_LD_HU;
            default: is_mem = 1'b0;
        endcase
        case (op6)
            6'h16:   tbl_sub = BR_EQ;
            6'h17:   tbl_sub = BR_NE;
            6'h18:   tbl_sub = BR_LT;
            6'h19:   tbl_sub = BR_GE;
            6'h1a:   tbl_sub = BR_LTU;
            6'h1b:   tbl_sub = BR_GEU;
            default: is_br = 1'b0;
        endcase
    end

    // Controls per instruction group
    always_comb
    begin
        n_alu     = tbl_alu;
        n_sub     = tbl_sub;
        n_class   = CLASS_ALU;
        n_src1    = 1'b0;
        n_src2    = SRC2_IMM;
        n_redir   = 1'b0;
        n_wr      = 1'b1;
        n_mrd     = 1'b0;
        n_mwr     = 1'b0;
        n_fmt     = IMM_NONE;
        n_rk      = word.reg_view.rk;
        n_rj      = word.reg_view.rj;
        n_rd      = word.reg_view.rd;
        n_excp    = 1'b0;
        n_code    = '0;
        n_subcode = 1'b0;
        if (adef || adem)
        begin
            n_excp    = 1'b1;
            n_code    = ECODE_ADE;
            n_subcode = adem;  // 0 ADEF, 1 ADEM
        end
        else if (is_r3)
            n_src2 = SRC2_REG;
        else if (is_shi)
        begin
            n_rk  = '0;
            n_fmt = IMM_UI5;
        end
        else if (is_i12)
        begin
            n_rk  = '0;
            n_fmt = op10[2] ? IMM_UI12 : IMM_SI12;  // Logic ops zero-extend
        end
        else if (is_mem)
        begin
            n_class = CLASS_MEM;
            n_rk    = '0;
            n_fmt   = IMM_SI12;
            n_mwr   = n_sub inside {MEM_ST_B, MEM_ST_H, MEM_ST_W};
            n_mrd   = !n_mwr;
            n_wr    = !n_mwr;  // Stores read rd as data
        end
        else if (op7 == 7'h0a || op7 == 7'h0e)  // LU12I.W, PCADDU12I
        begin
            n_rk   = '0;
            n_rj   = '0;
            n_fmt  = IMM_SI20;
            n_alu  = op7[2] ? ALU_ADD : ALU_PASS2;
            n_src1 = op7[2];
        end
        else if (op6 == 6'h13 || op6 == 6'h15)  // JIRL, BL
        begin
            n_class = CLASS_JUMP_LINK;
            n_rk    = '0;
            n_src1  = SRC1_PC;
            n_src2  = SRC2_FOUR;
            n_redir = 1'b1;
            n_fmt   = op6[1] ? IMM_OFFS16 : IMM_OFFS26;
            if (!op6[1])
            begin
                n_rj = '0;
                n_rd = 5'd1;  // BL links to r1
            end
        end
        else if (op6 == 6'h14 || is_br)  // B and conditional branches
        begin
            n_class = CLASS_BRANCH;
            n_rk    = '0;
            n_wr    = 1'b0;
            n_redir = 1'b1;
            n_src2  = is_br ? SRC2_RD : SRC2_REG;
            n_fmt   = is_br ? IMM_OFFS16 : IMM_OFFS26;
            case (n_sub)
                BR_EQ, BR_NE: n_alu = ALU_SUB;
                BR_LT, BR_GE: n_alu = ALU_SLT;
                default:      n_alu = ALU_SLTU;
            endcase
            if (!is_br)
            begin
                n_rj  = '0;
                n_rd  = '0;
                n_alu = ALU_ADD;
            end
        end
        else
        begin
            n_excp = 1'b1;
            if (op17 == 17'h00054)
                n_code = ECODE_BRK;
            else if (op17 == 17'h00056)
                n_code = ECODE_SYS;
            else
                n_code = ECODE_INE;  // Includes all dropped encodings
        end
        if (n_excp)
        begin
            n_class = CLASS_EXCP;
            n_alu   = '0;
            n_src1  = 1'b0;
            n_src2  = '0;
            n_sub   = '0;
            n_redir = 1'b0;
            n_wr    = 1'b0;
            n_mrd   = 1'b0;
            n_mwr   = 1'b0;
            n_fmt   = IMM_NONE;
            n_rk    = '0;
            n_rj    = '0;
            n_rd    = '0;
        end
    end

    imm_gen i_imm_gen (
        .imm_fmt (n_fmt),
        .word    (word),
        .imm     (n_imm)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            dec_valid <= 1'b0;
        else if (fetch_take)
            dec_valid <= 1'b1;
        else if (dec_take)
            dec_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (fetch_take)
        begin
            inst_class   <= n_class;
            alu_op       <= n_alu;
            src1_sel     <= n_src1;
            src2_sel     <= n_src2;
            sub_op       <= n_sub;
            pc_redirect  <= n_redir;
            reg_write    <= n_wr;
            mem_read     <= n_mrd;
            mem_write    <= n_mwr;
            rk           <= n_rk;
            rj           <= n_rj;
            rd           <= n_rd;
            imm          <= n_imm;
            pc_out       <= fetch_pc;
            excp_valid   <= n_excp;
            excp_code    <= n_code;
            excp_subcode <= n_subcode;
        end
    end

endmodule

`default_nettype wire

// ==== decode/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import la32_decode_pkg::*;
(
    input  logic [IMM_FMT_W-1:0] imm_fmt,
    input  inst_word_u           word,
    output logic [XLEN-1:0]      imm
);

    logic [15:0]          offs;
    logic [REG_IDX_W-1:0] hi_rj;
    logic [REG_IDX_W-1:0] hi_rd;

    assign offs  = word.imm_view.offs16;
    assign hi_rj = word.imm_view.rj;  // offs26 bits 25:21
    assign hi_rd = word.imm_view.rd;  // offs26 bits 20:16

    always_comb
    begin
        case (imm_fmt)
            IMM_UI5:    imm = {27'b0, word.reg_view.rk};
            IMM_SI12:   imm = {{20{offs[11]}}, offs[11:0]};
            IMM_UI12:   imm = {20'b0, offs[11:0]};
            IMM_SI20:   imm = {offs[14:0], word.reg_view.rj, 12'b0};  // ir[24:5] << 12
            IMM_OFFS16: imm = {{14{offs[15]}}, offs, 2'b0};
            IMM_OFFS26: imm = {{4{hi_rj[4]}}, hi_rj, hi_rd, offs, 2'b0};
            default:    imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_port
    import la32_decode_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_req,
    output logic            in_ack,
    input  logic [XLEN-1:0] ir,
    input  logic [XLEN-1:0] pc,
    output logic            fetch_valid,
    input  logic            fetch_take,
    output logic [XLEN-1:0] fetch_ir,
    output logic [XLEN-1:0] fetch_pc,
    output logic            adef,
    output logic            adem
);

    logic capture;

    assign capture = in_req && !in_ack && !fetch_valid;  // New request, slot empty

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            in_ack      <= 1'b0;
            fetch_valid <= 1'b0;
        end
        else
        begin
            if (capture)
                in_ack <= 1'b1;
            else if (in_ack && !in_req)
                in_ack <= 1'b0;  // Return-to-zero phase
            if (capture)
                fetch_valid <= 1'b1;
            else if (fetch_take)
                fetch_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            fetch_ir <= ir;
            fetch_pc <= pc;
            adef     <= |pc[1:0];                  // Misaligned fetch
            adem     <= ~|pc[1:0] && pc[XLEN-1];   // Upper half, ADEF wins
        end
    end

endmodule

`default_nettype wire

// ==== common/la32_decode_pkg.sv ====
`default_nettype none

package la32_decode_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_NOR   = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_XOR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLL   = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRL   = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SRA   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLT   = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 4'd10;
    localparam logic [ALU_OP_W-1:0] ALU_PASS2 = 4'd11;  // Result is operand 2

    localparam int CLASS_W = 3;
    localparam logic [CLASS_W-1:0] CLASS_ALU       = 3'd0;
    localparam logic [CLASS_W-1:0] CLASS_BRANCH    = 3'd1;
    localparam logic [CLASS_W-1:0] CLASS_MEM       = 3'd2;
    localparam logic [CLASS_W-1:0] CLASS_EXCP      = 3'd3;
    localparam logic [CLASS_W-1:0] CLASS_JUMP_LINK = 3'd4;

    localparam logic SRC1_PC = 1'b1;  // Zero selects rj

    localparam logic [1:0] SRC2_REG  = 2'd0;
    localparam logic [1:0] SRC2_IMM  = 2'd1;
    localparam logic [1:0] SRC2_RD   = 2'd2;  // Branch compare against rd
    localparam logic [1:0] SRC2_FOUR = 2'd3;  // Link address pc + 4

    localparam int SUB_OP_W = 3;
    localparam logic [SUB_OP_W-1:0] BR_ALWAYS = 3'd0;
    localparam logic [SUB_OP_W-1:0] BR_EQ     = 3'd1;
    localparam logic [SUB_OP_W-1:0] BR_NE     = 3'd2;
    localparam logic [SUB_OP_W-1:0] BR_LT     = 3'd3;
    localparam logic [SUB_OP_W-1:0] BR_GE     = 3'd4;
    localparam logic [SUB_OP_W-1:0] BR_LTU    = 3'd5;
    localparam logic [SUB_OP_W-1:0] BR_GEU    = 3'd6;
    localparam logic [SUB_OP_W-1:0] MEM_LD_B  = 3'd0;
    localparam logic [SUB_OP_W-1:0] MEM_LD_H  = 3'd1;
    localparam logic [SUB_OP_W-1:0] MEM_LD_W  = 3'd2;
    localparam logic [SUB_OP_W-1:0] MEM_ST_B  = 3'd3;
    localparam logic [SUB_OP_W-1:0] MEM_ST_H  = 3'd4;
    localparam logic [SUB_OP_W-1:0] MEM_ST_W  = 3'd5;
    localparam logic [SUB_OP_W-1:0] MEM_LD_BU = 3'd6;
    localparam logic [SUB_OP_W-1:0] MEM_LD_HU = 3'd7;

    localparam int IMM_FMT_W = 3;
    localparam logic [IMM_FMT_W-1:0] IMM_NONE   = 3'd0;
    localparam logic [IMM_FMT_W-1:0] IMM_UI5    = 3'd1;
    localparam logic [IMM_FMT_W-1:0] IMM_SI12   = 3'd2;
    localparam logic [IMM_FMT_W-1:0] IMM_UI12   = 3'd3;
    localparam logic [IMM_FMT_W-1:0] IMM_SI20   = 3'd4;
    localparam logic [IMM_FMT_W-1:0] IMM_OFFS16 = 3'd5;
    localparam logic [IMM_FMT_W-1:0] IMM_OFFS26 = 3'd6;

    localparam int ECODE_W = 6;
    localparam logic [ECODE_W-1:0] ECODE_ADE = 6'h08;
    localparam logic [ECODE_W-1:0] ECODE_SYS = 6'h0B;
    localparam logic [ECODE_W-1:0] ECODE_BRK = 6'h0C;
    localparam logic [ECODE_W-1:0] ECODE_INE = 6'h0D;

    // Same 32-bit word seen as register format or as offset format
    typedef union packed {
        struct packed {
            logic [16:0]          op17;  // ir[31:15]
            logic [REG_IDX_W-1:0] rk;
            logic [REG_IDX_W-1:0] rj;
            logic [REG_IDX_W-1:0] rd;
        } reg_view;
        struct packed {
            logic [5:0]           op6;     // ir[31:26]
            logic [15:0]          offs16;  // ir[25:10]
            logic [REG_IDX_W-1:0] rj;
            logic [REG_IDX_W-1:0] rd;
        } imm_view;
    } inst_word_u;

endpackage

`default_nettype wire
